/* hdl/vc_router_defs.svh */
// ##########################################################
// one output port of a 5-port router, VC count equals next-hop count
// BUF_DEPTH must match the slot count of the downstream input buffer
// ##########################################################
`ifndef VC_ROUTER_DEFS_SVH
`define VC_ROUTER_DEFS_SVH

// router input ports: north, east, south, west, local
`define NUM_INPUTS 5

// downstream VCs, one per next-hop direction (never back where it came from)
`define NUM_VC 4
`define VC_ID_W 2

// flit slots per downstream VC
`define BUF_DEPTH 2

// direction of this output port (east)
`define OUTPUT_ID 1

// VC reserved for wormhole continuation flits
`define WORMHOLE_VC 0

`endif

/* hdl/vc_router_pkg.sv */
// ##########################################################
// preferred_vc implements the general mapping only, no XY variant
// ##########################################################
`default_nettype none

`include "vc_router_defs.svh"

package vc_router_pkg;

  typedef enum logic [2:0] {
    DIR_NORTH = 3'd0,
    DIR_EAST  = 3'd1,
    DIR_SOUTH = 3'd2,
    DIR_WEST  = 3'd3,
    DIR_EJECT = 3'd4
  } route_dir_e;

  typedef logic [`VC_ID_W-1:0] vc_id_t;

  // credit returned by the downstream router
  typedef struct packed {
    logic   valid;
    vc_id_t id;
  } credit_t;

  // precomputed VC for one next-hop direction
  typedef struct packed {
    logic   valid;
    vc_id_t id;
  } vc_sel_t;

  typedef struct packed {
    logic       valid;
    vc_id_t     id;
    route_dir_e dir;
  } vc_assign_t;

  // next router has no VC towards the port the flit enters on,
  // so directions above that input id shift down by one
  function automatic vc_id_t preferred_vc(route_dir_e dir);
    int unsigned in_id;
    int unsigned idx;
    in_id = (`OUTPUT_ID < 4) ? (`OUTPUT_ID + 2) % 4 : `OUTPUT_ID;
    idx = int'(dir);
    if (idx > in_id) begin
      idx = idx - 1;
    end
    return vc_id_t'(idx % `NUM_VC);
  endfunction

endpackage

`default_nettype wire

/* hdl/vc_credit_counter.sv */
// ##########################################################
// counters start full at BUF_DEPTH; caller sends only with a credit
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

`include "vc_router_defs.svh"

module vc_credit_counter import vc_router_pkg::*; (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic              send_v_i,
  input  wire vc_id_t            send_id_i,
  input  wire credit_t           credit_i,
  output logic [`NUM_VC-1:0]     vc_not_full_o
);

  localparam int CNT_W = $clog2(`BUF_DEPTH + 1);

  logic [CNT_W-1:0] cnt_q [`NUM_VC];
  logic [`NUM_VC-1:0] inc;
  logic [`NUM_VC-1:0] dec;

  for (genvar v = 0; v < `NUM_VC; v++) begin : gen_vc
    // one slot freed downstream / one slot taken by a leaving flit
    assign inc[v] = credit_i.valid && (credit_i.id == vc_id_t'(v));
    assign dec[v] = send_v_i && (send_id_i == vc_id_t'(v));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt_q[v] <= CNT_W'(`BUF_DEPTH);
      end else begin
        // send and credit together cancel out
        if (inc[v] && !dec[v]) begin
          if (cnt_q[v] != CNT_W'(`BUF_DEPTH)) begin
            cnt_q[v] <= cnt_q[v] + 1'b1;
          end
        end else if (dec[v] && !inc[v]) begin
          if (cnt_q[v] != '0) begin
            cnt_q[v] <= cnt_q[v] - 1'b1;
          end
        end
      end
    end

    assign vc_not_full_o[v] = (cnt_q[v] != '0);
  end

endmodule

`default_nettype wire

/* hdl/vc_selection.sv */
// ##########################################################
// purely combinational; fallback is always the lowest free VC
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

`include "vc_router_defs.svh"

module vc_selection import vc_router_pkg::*; (
  input  wire logic [`NUM_VC-1:0]     vc_not_full_i,
  // indexed by next-hop direction, eject shares the local slot
  output vc_sel_t [`NUM_INPUTS-1:0]   sel_o
);

  logic   low_v;
  vc_id_t low_id;

  // lowest index VC that still has credits
  always_comb begin
    low_v  = 1'b0;
    low_id = '0;
    for (int v = `NUM_VC - 1; v >= 0; v--) begin
      if (vc_not_full_i[v]) begin
        low_v  = 1'b1;
        low_id = vc_id_t'(v);
      end
    end
  end

  for (genvar d = 0; d < `NUM_INPUTS; d++) begin : gen_dir
    vc_id_t pref;

    assign pref = preferred_vc(route_dir_e'(d));

    always_comb begin
      if (vc_not_full_i[pref]) begin
        sel_o[d].valid = 1'b1;
        sel_o[d].id    = pref;
      end else begin
        // preferred VC exhausted, fall back
        sel_o[d].valid = low_v;
        sel_o[d].id    = low_id;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/sa_global_arbiter.sv */
// ##########################################################
// pointer moves only on accept, so a stalled winner is offered again
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

`include "vc_router_defs.svh"

module sa_global_arbiter (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  input  wire logic [`NUM_INPUTS-1:0]  req_i,
  input  wire logic                    accept_i,
  output logic                         grant_v_o,
  output logic [`NUM_INPUTS-1:0]       grant_oh_o
);

  localparam int PTR_W = $clog2(`NUM_INPUTS);

  logic [PTR_W-1:0] ptr_q;
  logic [PTR_W-1:0] ptr_d;
  logic [PTR_W-1:0] win_idx;

  // search starts at the pointer and wraps around
  always_comb begin
    int idx;
    grant_v_o  = 1'b0;
    grant_oh_o = '0;
    win_idx    = ptr_q;
    for (int i = 0; i < `NUM_INPUTS; i++) begin
      idx = (int'(ptr_q) + i) % `NUM_INPUTS;
      if (!grant_v_o && req_i[idx]) begin
        grant_v_o       = 1'b1;
        grant_oh_o[idx] = 1'b1;
        win_idx         = PTR_W'(idx);
      end
    end
  end

  // winner gets lowest priority next time
  always_comb begin
    if (win_idx == PTR_W'(`NUM_INPUTS - 1)) begin
      ptr_d = '0;
    end else begin
      ptr_d = win_idx + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (accept_i && grant_v_o) begin
      ptr_q <= ptr_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/vc_assignment.sv */
// ##########################################################
// wormhole flits always use WORMHOLE_VC; others may not fall back onto it
// credit shortcut relies on the counter netting send and credit
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

`include "vc_router_defs.svh"

module vc_assignment import vc_router_pkg::*; (
  input  wire logic                          grant_v_i,
  input  wire logic [`NUM_INPUTS-1:0]        grant_oh_i,
  input  wire route_dir_e [`NUM_INPUTS-1:0]  look_ahead_i,
  input  wire vc_sel_t [`NUM_INPUTS-1:0]     sel_i,
  input  wire logic [`NUM_VC-1:0]            vc_not_full_i,
  input  wire logic                          wormhole_i,
  input  wire credit_t                       credit_i,
  output vc_assign_t                         assign_o
);

  logic [2:0] la_bits;
  route_dir_e la_sel;
  vc_id_t     pref;
  vc_sel_t    sel;
  logic       cred_pref;
  logic       cred_worm;
  logic       fallback_worm;

  // one-hot mux of the look-ahead direction of the winner
  always_comb begin
    la_bits = '0;
    for (int i = 0; i < `NUM_INPUTS; i++) begin
      if (grant_oh_i[i]) begin
        la_bits = la_bits | look_ahead_i[i];
      end
    end
  end

  assign la_sel = route_dir_e'(la_bits);
  assign pref   = preferred_vc(la_sel);
  assign sel    = sel_i[la_sel];

  // credits arriving this cycle
  assign cred_pref = credit_i.valid && (credit_i.id == pref);
  assign cred_worm = credit_i.valid && (credit_i.id == vc_id_t'(`WORMHOLE_VC));

  // selection only landed on the wormhole VC because preferred was full
  assign fallback_worm = (sel.id == vc_id_t'(`WORMHOLE_VC)) && (sel.id != pref);

  always_comb begin
    assign_o.valid = 1'b0;
    assign_o.id    = '0;
    assign_o.dir   = la_sel;
    if (grant_v_i) begin
      if (wormhole_i) begin
        // continuation flit, fixed VC
        assign_o.id    = vc_id_t'(`WORMHOLE_VC);
        assign_o.valid = vc_not_full_i[`WORMHOLE_VC] || cred_worm;
      end else if (cred_pref) begin
        assign_o.id    = pref;
        assign_o.valid = 1'b1;
      end else begin
        assign_o.id    = sel.id;
        assign_o.valid = sel.valid && !fallback_worm;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/output_port_alloc.sv */
// ##########################################################
// allocation for one output port; requests to grant in a single cycle
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

`include "vc_router_defs.svh"

module output_port_alloc import vc_router_pkg::*; (
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,
  input  wire logic [`NUM_INPUTS-1:0]        req_i,
  input  wire route_dir_e [`NUM_INPUTS-1:0]  look_ahead_i,
  input  wire logic                          wormhole_i,
  input  wire credit_t                       credit_i,
  output logic [`NUM_INPUTS-1:0]             grant_o,
  output vc_assign_t                         assign_o
);

  logic [`NUM_VC-1:0]          vc_not_full;
  vc_sel_t [`NUM_INPUTS-1:0]   vc_sel;
  logic                        grant_v;

  vc_credit_counter u_credit (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .send_v_i      (assign_o.valid),
    .send_id_i     (assign_o.id),
    .credit_i      (credit_i),
    .vc_not_full_o (vc_not_full)
  );

  vc_selection u_vc_sel (
    .vc_not_full_i (vc_not_full),
    .sel_o         (vc_sel)
  );

  // a valid assignment is what lets the arbiter advance
  sa_global_arbiter u_sa (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .accept_i   (assign_o.valid),
    .grant_v_o  (grant_v),
    .grant_oh_o (grant_o)
  );

  vc_assignment u_vc_assign (
    .grant_v_i     (grant_v),
    .grant_oh_i    (grant_o),
    .look_ahead_i  (look_ahead_i),
    .sel_i         (vc_sel),
    .vc_not_full_i (vc_not_full),
    .wormhole_i    (wormhole_i),
    .credit_i      (credit_i),
    .assign_o      (assign_o)
  );

endmodule

`default_nettype wire

/* test/tb_output_port_alloc.sv */
// ##########################################################
// expected values assume OUTPUT_ID east, BUF_DEPTH 2, WORMHOLE_VC 0
// each row starts from the state the rows before it left
// ##########################################################
`timescale 1ns/1ns
`default_nettype none

`include "vc_router_defs.svh"

module tb_output_port_alloc import vc_router_pkg::*; ();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;

  typedef route_dir_e [`NUM_INPUTS-1:0] la_vec_t;

  // one table row with stimulus and expected response
  typedef struct packed {
    logic [`NUM_INPUTS-1:0] req;
    la_vec_t                la;
    logic                   wormhole;
    credit_t                credit;
    logic [`NUM_INPUTS-1:0] grant;
    vc_assign_t             result;
  } row_t;

  localparam credit_t NO_CR = '0;

  logic                   clk;
  logic                   rst_n;
  logic [`NUM_INPUTS-1:0] req;
  la_vec_t                look_ahead;
  logic                   wormhole;
  credit_t                credit;
  logic [`NUM_INPUTS-1:0] grant;
  vc_assign_t             assign_res;

  row_t  rows[$];
  string names[$];
  int    cycles      = 0;
  int    cycle_limit = 0;

  output_port_alloc dut0 (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (req),
    .look_ahead_i (look_ahead),
    .wormhole_i   (wormhole),
    .credit_i     (credit),
    .grant_o      (grant),
    .assign_o     (assign_res)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: table did not complete within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $fatal(1, "run aborted on timeout");
    end
  end

  function automatic la_vec_t all_dir(route_dir_e d);
    la_vec_t v;
    for (int i = 0; i < `NUM_INPUTS; i++) begin
      v[i] = d;
    end
    return v;
  endfunction

  // arguments run from the local input down to the north input
  function automatic la_vec_t dirs(route_dir_e d4, route_dir_e d3, route_dir_e d2,
                                   route_dir_e d1, route_dir_e d0);
    la_vec_t v;
    v[4] = d4;
    v[3] = d3;
    v[2] = d2;
    v[1] = d1;
    v[0] = d0;
    return v;
  endfunction

  function automatic credit_t credit_of(logic v, vc_id_t id);
    credit_t c;
    c.valid = v;
    c.id    = id;
    return c;
  endfunction

  function automatic vc_assign_t result_of(logic v, vc_id_t id, route_dir_e d);
    vc_assign_t r;
    r.valid = v;
    r.id    = id;
    r.dir   = d;
    return r;
  endfunction

  task automatic add_row(input string name, input logic [`NUM_INPUTS-1:0] r,
                         input la_vec_t la, input logic wh, input credit_t cr,
                         input logic [`NUM_INPUTS-1:0] g, input vc_assign_t res);
    row_t row;
    row.req      = r;
    row.la       = la;
    row.wormhole = wh;
    row.credit   = cr;
    row.grant    = g;
    row.result   = res;
    rows.push_back(row);
    names.push_back(name);
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      $display("ERR %s %s: expected %0h, actual %0h", name, what, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "mismatch in row %s", name);
    end
  endtask

  // preferred VC for the east output is 0 1 2 3 3 for N E S W eject
  task automatic build_table();
    add_row("idle", 5'b00000, all_dir(DIR_NORTH), 1'b0, NO_CR,
            5'b00000, result_of(1'b0, 2'd0, DIR_NORTH));
    // reset state and round robin with a credit back on VC0 each cycle
    add_row("reset_win0", 5'b11111, all_dir(DIR_NORTH), 1'b0, credit_of(1'b1, 2'd0),
            5'b00001, result_of(1'b1, 2'd0, DIR_NORTH));
    add_row("rr_east", 5'b11111, all_dir(DIR_NORTH), 1'b0, credit_of(1'b1, 2'd0),
            5'b00010, result_of(1'b1, 2'd0, DIR_NORTH));
    add_row("rr_south", 5'b11111, all_dir(DIR_NORTH), 1'b0, credit_of(1'b1, 2'd0),
            5'b00100, result_of(1'b1, 2'd0, DIR_NORTH));
    add_row("rr_west", 5'b11111, all_dir(DIR_NORTH), 1'b0, credit_of(1'b1, 2'd0),
            5'b01000, result_of(1'b1, 2'd0, DIR_NORTH));
    add_row("rr_local", 5'b11111, all_dir(DIR_NORTH), 1'b0, credit_of(1'b1, 2'd0),
            5'b10000, result_of(1'b1, 2'd0, DIR_NORTH));
    add_row("rr_north_again", 5'b11111, all_dir(DIR_NORTH), 1'b0, credit_of(1'b1, 2'd0),
            5'b00001, result_of(1'b1, 2'd0, DIR_NORTH));
    // single requester on input 2 with one send per direction
    add_row("map_north", 5'b00100, all_dir(DIR_NORTH), 1'b0, NO_CR,
            5'b00100, result_of(1'b1, 2'd0, DIR_NORTH));
    add_row("map_east", 5'b00100, all_dir(DIR_EAST), 1'b0, NO_CR,
            5'b00100, result_of(1'b1, 2'd1, DIR_EAST));
    add_row("map_south", 5'b00100, all_dir(DIR_SOUTH), 1'b0, NO_CR,
            5'b00100, result_of(1'b1, 2'd2, DIR_SOUTH));
    add_row("map_west", 5'b00100, all_dir(DIR_WEST), 1'b0, NO_CR,
            5'b00100, result_of(1'b1, 2'd3, DIR_WEST));
    add_row("map_eject", 5'b00100, all_dir(DIR_EJECT), 1'b0, NO_CR,
            5'b00100, result_of(1'b1, 2'd3, DIR_EJECT));
    // VC3 is empty now and fallback may not land on the wormhole VC
    add_row("fallback_worm_blocked", 5'b00100, all_dir(DIR_WEST), 1'b0, NO_CR,
            5'b00100, result_of(1'b0, 2'd0, DIR_WEST));
    add_row("drain_vc0", 5'b00100, all_dir(DIR_NORTH), 1'b0, NO_CR,
            5'b00100, result_of(1'b1, 2'd0, DIR_NORTH));
    add_row("fallback_vc1", 5'b00100, all_dir(DIR_WEST), 1'b0, NO_CR,
            5'b00100, result_of(1'b1, 2'd1, DIR_WEST));
    add_row("fallback_vc2", 5'b00100, all_dir(DIR_WEST), 1'b0, NO_CR,
            5'b00100, result_of(1'b1, 2'd2, DIR_WEST));
    // every VC exhausted with the pointer at input 3
    add_row("all_full", 5'b11111, dirs(DIR_NORTH, DIR_WEST, DIR_SOUTH, DIR_EAST, DIR_NORTH),
            1'b0, NO_CR, 5'b01000, result_of(1'b0, 2'd0, DIR_WEST));
    add_row("ptr_held", 5'b11111, dirs(DIR_NORTH, DIR_WEST, DIR_SOUTH, DIR_EAST, DIR_NORTH),
            1'b0, NO_CR, 5'b01000, result_of(1'b0, 2'd0, DIR_WEST));
    add_row("credit_shortcut", 5'b11111,
            dirs(DIR_NORTH, DIR_WEST, DIR_SOUTH, DIR_EAST, DIR_NORTH),
            1'b0, credit_of(1'b1, 2'd3), 5'b01000, result_of(1'b1, 2'd3, DIR_WEST));
    add_row("shortcut_count_zero", 5'b00100, all_dir(DIR_WEST), 1'b0, NO_CR,
            5'b00100, result_of(1'b0, 2'd0, DIR_WEST));
    // wormhole continuation flits
    add_row("wormhole_empty", 5'b00100, all_dir(DIR_SOUTH), 1'b1, NO_CR,
            5'b00100, result_of(1'b0, 2'd0, DIR_SOUTH));
    add_row("wormhole_credit", 5'b00100, all_dir(DIR_SOUTH), 1'b1, credit_of(1'b1, 2'd0),
            5'b00100, result_of(1'b1, 2'd0, DIR_SOUTH));
    add_row("credit_return_vc0", 5'b00000, all_dir(DIR_NORTH), 1'b0, credit_of(1'b1, 2'd0),
            5'b00000, result_of(1'b0, 2'd0, DIR_NORTH));
    add_row("wormhole_dir_east", 5'b00010, all_dir(DIR_EAST), 1'b1, NO_CR,
            5'b00010, result_of(1'b1, 2'd0, DIR_EAST));
    add_row("credit_return_vc2", 5'b00000, all_dir(DIR_NORTH), 1'b0, credit_of(1'b1, 2'd2),
            5'b00000, result_of(1'b0, 2'd0, DIR_NORTH));
    add_row("wormhole_ignores_pref", 5'b00100, all_dir(DIR_SOUTH), 1'b1, NO_CR,
            5'b00100, result_of(1'b0, 2'd0, DIR_SOUTH));
    add_row("normal_after_wormhole", 5'b00100, all_dir(DIR_SOUTH), 1'b0, NO_CR,
            5'b00100, result_of(1'b1, 2'd2, DIR_SOUTH));
  endtask

  initial begin
    int idx;
    req        = '0;
    look_ahead = all_dir(DIR_NORTH);
    wormhole   = 1'b0;
    credit     = NO_CR;
    rst_n      = 1'b0;
    build_table();
    cycle_limit = rows.size() + RESET_CYCLES + 20;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (idx = 0; idx < rows.size(); idx++) begin
      @(negedge clk);
      req        = rows[idx].req;
      look_ahead = rows[idx].la;
      wormhole   = rows[idx].wormhole;
      credit     = rows[idx].credit;
      // combinational outputs are sampled just ahead of the next edge
      #(CLK_PERIOD / 2 - 1);
      check_value(names[idx], "grant", 8'(rows[idx].grant), 8'(grant));
      check_value(names[idx], "assign", 8'(rows[idx].result), 8'(assign_res));
    end

    @(negedge clk);
    req    = '0;
    credit = NO_CR;

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/vc_router_pkg.sv
hdl/vc_credit_counter.sv
hdl/vc_selection.sv
hdl/sa_global_arbiter.sv
hdl/vc_assignment.sv
hdl/output_port_alloc.sv
test/tb_output_port_alloc.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

TOP=tb_output_port_alloc
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module "$TOP" -f vlog.f -o "$TOP"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi
